//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_yuv420 -f vlog.f \
   && ./obj_dir/Vtb_yuv420 > sim.log 2>&1 \
   || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation FAIL"; exit 1; } \
   || { echo "simulation PASS"; exit 0; }

//--- tb_yuv420.sv
module tb_yuv420;
   timeunit 1ns;
   timeprecision 1ps;

   import yuv_stream_pkg::*;
   import yuv_format_pkg::*;

   localparam int DIM_BITS = $clog2(MAX_COLS_DEFAULT);
   localparam int MAX_DIM = 8;
   localparam int CLK_PERIOD = 8;
   // items driven by the six tests plus reset and per-test settling cycles
   localparam int TEST_ITEMS = 2 + 26 + 34 + 16 + 47 + 6;
   localparam int EXTRA_CYCLES = 8 + 6 * 16;
   localparam int TIMEOUT_NS = (TEST_ITEMS + EXTRA_CYCLES) * CLK_PERIOD * 4;

   logic clk;
   logic resetb;
   logic enable_420;
   logic dvi;
   dtype_t dtypei;
   logic [META_BITS-1:0] meta_datai;
   logic [PIXEL_BITS-1:0] yi;
   logic [PIXEL_BITS-1:0] ui;
   logic [PIXEL_BITS-1:0] vi;
   logic dvo;
   dtype_t dtypeo;
   logic [WORD_BITS-1:0] datao;
   logic [DIM_BITS-1:0] num_rows;
   logic [DIM_BITS-1:0] num_cols;

   logic [31:0] lfsr_state;
   int errors;
   int checks;
   int cycle_cnt = 0;

   // reference byte stream and expected / collected output items
   logic [7:0] byte_q[$];
   dtype_t exp_type[$];
   logic [31:0] exp_data[$];
   dtype_t got_type[$];
   logic [31:0] got_data[$];
   int got_cycle[$];

   logic [7:0] frame_y [MAX_DIM][MAX_DIM];
   logic [7:0] frame_u [MAX_DIM][MAX_DIM];
   logic [7:0] frame_v [MAX_DIM][MAX_DIM];

   yuv420_stream_top #(
      .MAX_COLS(MAX_COLS_DEFAULT)
   ) dut (
      .clk        (clk),
      .resetb     (resetb),
      .enable_420 (enable_420),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .meta_datai (meta_datai),
      .yi         (yi),
      .ui         (ui),
      .vi         (vi),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao),
      .num_rows   (num_rows),
      .num_cols   (num_cols)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // outputs change on the rising edge and are collected on the falling edge
   always @(negedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (resetb && dvo) begin
         got_type.push_back(dtypeo);
         got_data.push_back(datao);
         got_cycle.push_back(cycle_cnt);
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("tests failed");
      $finish;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'hA300_0000;
      end else begin
         return s >> 1;
      end
   endfunction

   // one LFSR step per random bit
   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      for (int i = 0; i < 8; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         b[i] = lfsr_state[0];
      end
      return b;
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic drive_item(input dtype_t t, input logic [7:0] y, input logic [7:0] u,
                             input logic [7:0] v, input logic [15:0] meta);
      @(negedge clk);
      dvi = 1'b1;
      dtypei = t;
      yi = y;
      ui = u;
      vi = v;
      meta_datai = meta;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         dvi = 1'b0;
      end
   endtask

   task automatic push_expected(input dtype_t t, input logic [31:0] d);
      exp_type.push_back(t);
      exp_data.push_back(d);
   endtask

   task automatic clear_queues();
      byte_q.delete();
      exp_type.delete();
      exp_data.delete();
      got_type.delete();
      got_data.delete();
      got_cycle.delete();
   endtask

   // first byte of the stream lands in bits 7:0
   task automatic add_byte(input logic [7:0] b);
      byte_q.push_back(b);
      if (byte_q.size() == 4) begin
         push_expected(DTYPE_PIXEL, {byte_q[3], byte_q[2], byte_q[1], byte_q[0]});
         byte_q.delete();
      end
   endtask

   task automatic model_frame_end();
      if (byte_q.size() != 0) begin
         while (byte_q.size() != 0) begin
            add_byte(8'h00);
         end
      end
      push_expected(DTYPE_FRAME_END, '0);
   endtask

   task automatic model_pixel(input int r, input int c, input logic mode);
      logic [9:0] su;
      logic [9:0] sv;
      add_byte(frame_y[r][c]);
      if (!mode) begin
         add_byte(frame_u[r][c]);
         add_byte(frame_v[r][c]);
      end else if ((r % 2 == 1) && (c % 2 == 1)) begin
         // floored mean of rows r-1..r and columns c-1..c
         su = 10'(frame_u[r-1][c-1]) + 10'(frame_u[r-1][c])
            + 10'(frame_u[r][c-1]) + 10'(frame_u[r][c]);
         sv = 10'(frame_v[r-1][c-1]) + 10'(frame_v[r-1][c])
            + 10'(frame_v[r][c-1]) + 10'(frame_v[r][c]);
         add_byte(su[9:2]);
         add_byte(sv[9:2]);
      end
   endtask

   task automatic send_frame(input int rows, input int cols, input logic mode);
      for (int r = 0; r < rows; r++) begin
         for (int c = 0; c < cols; c++) begin
            frame_y[r][c] = rand_byte();
            frame_u[r][c] = rand_byte();
            frame_v[r][c] = rand_byte();
         end
      end
      @(negedge clk);
      dvi = 1'b0;
      enable_420 = mode;
      drive_item(DTYPE_FRAME_START, 0, 0, 0, 0);
      push_expected(DTYPE_FRAME_START, '0);
      for (int r = 0; r < rows; r++) begin
         drive_item(DTYPE_ROW_START, 0, 0, 0, 0);
         push_expected(DTYPE_ROW_START, '0);
         for (int c = 0; c < cols; c++) begin
            drive_item(DTYPE_PIXEL, frame_y[r][c], frame_u[r][c], frame_v[r][c], 0);
            model_pixel(r, c, mode);
         end
         drive_item(DTYPE_ROW_END, 0, 0, 0, 0);
         push_expected(DTYPE_ROW_END, '0);
      end
      drive_item(DTYPE_FRAME_END, 0, 0, 0, 0);
      model_frame_end();
      // gap so the held frame end token is not displaced
      idle_cycles(3);
   endtask

   task automatic compare_outputs(input string name);
      int limit;
      int n;
      limit = 0;
      while ((got_type.size() < exp_type.size()) && (limit < 64)) begin
         @(negedge clk);
         limit++;
      end
      if (got_type.size() < exp_type.size()) begin
         errors++;
         $display("%s: timed out waiting for %0d output items, only %0d arrived",
                  name, exp_type.size(), got_type.size());
      end
      repeat (4) @(negedge clk);
      check_value({name, " output count"}, got_type.size(), exp_type.size());
      n = (got_type.size() < exp_type.size()) ? got_type.size() : exp_type.size();
      for (int i = 0; i < n; i++) begin
         check_value($sformatf("%s item %0d type", name, i), 32'(got_type[i]),
                     32'(exp_type[i]));
         check_value($sformatf("%s item %0d data", name, i), got_data[i], exp_data[i]);
      end
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      check_value("dvo after reset", 32'(dvo), 0);
      check_value("num_rows after reset", 32'(num_rows), 720);
      check_value("num_cols after reset", 32'(num_cols), 1280);
      drive_item(DTYPE_FRAME_START, 0, 0, 0, 0);
      idle_cycles(1);
      check_value("dvo one cycle after frame start", 32'(dvo), 0);
      idle_cycles(1);
      check_value("dvo two cycles after frame start", 32'(dvo), 1);
      check_value("frame start token type", 32'(dtypeo), 32'(DTYPE_FRAME_START));
      check_value("frame start token data", datao, 0);
      idle_cycles(2);
   endtask

   task automatic test_full_chroma();
      clear_queues();
      send_frame(4, 4, 1'b0);
      compare_outputs("full chroma frame");
   endtask

   task automatic test_420_frame();
      clear_queues();
      send_frame(4, 6, 1'b1);
      compare_outputs("420 frame");
   endtask

   // 10 luma bytes plus two chroma pairs leave 2 bytes over
   task automatic test_flush();
      int n;
      clear_queues();
      send_frame(2, 5, 1'b1);
      compare_outputs("flush frame");
      n = got_type.size();
      if (n < 2) begin
         errors++;
         $display("flush frame: fewer than two output items, no flush to inspect");
      end else begin
         check_value("flush word type", 32'(got_type[n-2]), 32'(DTYPE_PIXEL));
         check_value("flush word pad", 32'(got_data[n-2][31:16]), 0);
         check_value("token after flush", 32'(got_type[n-1]), 32'(DTYPE_FRAME_END));
         check_value("token cycle after flush", got_cycle[n-1], got_cycle[n-2] + 1);
      end
   endtask

   task automatic test_size();
      clear_queues();
      send_frame(5, 7, 1'b1);
      compare_outputs("size frame");
      check_value("num_rows measured", 32'(num_rows), 4);
      check_value("num_cols measured", 32'(num_cols), 6);
   endtask

   task automatic test_header_pairing();
      logic [15:0] w [4];
      clear_queues();
      for (int i = 0; i < 4; i++) begin
         w[i] = {rand_byte(), rand_byte()};
      end
      drive_item(DTYPE_HEADER_START, 0, 0, 0, 0);
      push_expected(DTYPE_HEADER_START, '0);
      for (int i = 0; i < 4; i++) begin
         drive_item(DTYPE_HEADER, 0, 0, 0, w[i]);
      end
      push_expected(DTYPE_HEADER, {w[1], w[0]});
      push_expected(DTYPE_HEADER, {w[3], w[2]});
      drive_item(DTYPE_HEADER_END, 0, 0, 0, 0);
      push_expected(DTYPE_HEADER_END, '0);
      idle_cycles(3);
      compare_outputs("header pairing");
   endtask

   initial begin
      errors = 0;
      checks = 0;
      lfsr_state = 32'h9cdf_8040;
      resetb = 1'b0;
      enable_420 = 1'b0;
      dvi = 1'b0;
      dtypei = DTYPE_FRAME_START;
      meta_datai = '0;
      yi = '0;
      ui = '0;
      vi = '0;
      repeat (8) @(negedge clk);
      resetb = 1'b1;
      test_reset_state();
      test_full_chroma();
      test_420_frame();
      test_flush();
      test_size();
      test_header_pairing();
      $display("test summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- uv_kernel.sv
module uv_kernel #(
   parameter int MAX_COLS = yuv_format_pkg::MAX_COLS_DEFAULT
) (
   input  logic                                  clk,
   input  logic                                  resetb,
   input  logic                                  enable_420,
   input  logic                                  dvi,
   input  yuv_stream_pkg::dtype_t                dtypei,
   input  logic [yuv_stream_pkg::META_BITS-1:0]  meta_datai,
   input  logic [yuv_stream_pkg::PIXEL_BITS-1:0] yi,
   input  logic [yuv_stream_pkg::PIXEL_BITS-1:0] ui,
   input  logic [yuv_stream_pkg::PIXEL_BITS-1:0] vi,
   output logic [$clog2(MAX_COLS)-1:0]           num_rows,
   output logic [$clog2(MAX_COLS)-1:0]           num_cols,
   yuv_pixel_if.src                              px
);
   import yuv_stream_pkg::*;
   import yuv_format_pkg::*;

   localparam int DIM_BITS = $clog2(MAX_COLS);
   localparam int UV_BITS = 2 * PIXEL_BITS;
   localparam int SUM_BITS = PIXEL_BITS + 2;

   logic pixel_in;
   logic frame_start_in;
   logic frame_end_in;
   logic row_start_in;
   logic row_end_in;

   logic [DIM_BITS-1:0] row_cnt;
   logic [DIM_BITS-1:0] col_cnt;

   // previous row of chroma, indexed by column
   logic [UV_BITS-1:0] line_mem [MAX_COLS];
   logic [UV_BITS-1:0] above_uv;

   // left neighbours in the current and previous rows
   logic [UV_BITS-1:0] left_uv;
   logic [UV_BITS-1:0] left_above_uv;

   // registered stream item
   logic dv_q;
   dtype_t dtype_q;
   logic en_q;
   logic row_odd_q;
   logic col_odd_q;
   logic [PIXEL_BITS-1:0] y_q;
   logic [PIXEL_BITS-1:0] u_q;
   logic [PIXEL_BITS-1:0] v_q;
   logic [META_BITS-1:0] meta_q;

   logic pixel_q;
   logic [SUM_BITS-1:0] u_sum;
   logic [SUM_BITS-1:0] v_sum;

   assign pixel_in = dvi && |(dtypei & DTYPE_PIXEL_MASK);
   assign frame_start_in = dvi && (dtypei == DTYPE_FRAME_START);
   assign frame_end_in = dvi && (dtypei == DTYPE_FRAME_END);
   assign row_start_in = dvi && (dtypei == DTYPE_ROW_START);
   assign row_end_in = dvi && (dtypei == DTYPE_ROW_END);

   // row and column position of the incoming pixel, size latched at frame end
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_cnt <= '0;
         col_cnt <= '0;
         num_rows <= DIM_BITS'(RESET_ROWS);
         num_cols <= DIM_BITS'(RESET_COLS);
      end else begin
         if (frame_start_in) begin
            row_cnt <= '0;
         end else if (row_end_in) begin
            row_cnt <= row_cnt + 1'b1;
         end
         if (row_start_in) begin
            col_cnt <= '0;
         end else if (pixel_in) begin
            col_cnt <= col_cnt + 1'b1;
         end
         // sizes rounded down to even for the 2x2 subsampling
         if (frame_end_in) begin
            num_rows <= {row_cnt[DIM_BITS-1:1], 1'b0};
            num_cols <= {col_cnt[DIM_BITS-1:1], 1'b0};
         end
      end
   end

   // read the pixel above before it is overwritten by this row
   always_ff @(posedge clk) begin
      if (pixel_in) begin
         above_uv <= line_mem[col_cnt];
         line_mem[col_cnt] <= {ui, vi};
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dv_q <= 1'b0;
         dtype_q <= DTYPE_FRAME_START;
         en_q <= 1'b0;
         row_odd_q <= 1'b0;
         col_odd_q <= 1'b0;
      end else begin
         dv_q <= dvi;
         dtype_q <= dtypei;
         en_q <= enable_420;
         row_odd_q <= row_cnt[0];
         col_odd_q <= col_cnt[0];
      end
   end

   always_ff @(posedge clk) begin
      y_q <= yi;
      u_q <= ui;
      v_q <= vi;
      meta_q <= meta_datai;
   end

   assign pixel_q = dv_q && |(dtype_q & DTYPE_PIXEL_MASK);

   // shift the 2x2 window one column along the row
   always_ff @(posedge clk) begin
      if (pixel_q) begin
         left_uv <= {u_q, v_q};
         left_above_uv <= above_uv;
      end
   end

   // sum of rows r-1 and r over columns c-1 and c
   assign u_sum = {2'b00, u_q}
                + {2'b00, above_uv[UV_BITS-1:PIXEL_BITS]}
                + {2'b00, left_uv[UV_BITS-1:PIXEL_BITS]}
                + {2'b00, left_above_uv[UV_BITS-1:PIXEL_BITS]};
   assign v_sum = {2'b00, v_q}
                + {2'b00, above_uv[PIXEL_BITS-1:0]}
                + {2'b00, left_uv[PIXEL_BITS-1:0]}
                + {2'b00, left_above_uv[PIXEL_BITS-1:0]};

   // in 420 mode only the odd/odd pixel closes a block and carries chroma
   assign px.emit_uv = !en_q || (row_odd_q && col_odd_q);
   assign px.u = en_q ? u_sum[SUM_BITS-1:2] : u_q;
   assign px.v = en_q ? v_sum[SUM_BITS-1:2] : v_q;
   assign px.dv = dv_q;
   assign px.dtype = dtype_q;
   assign px.y = y_q;
   assign px.meta = meta_q;

   // a pixel never lands past the end of the line buffer
   a_col_in_range : assert property (
      @(posedge clk) disable iff (!resetb) pixel_in |-> (int'(col_cnt) < MAX_COLS)
   ) else $error("uv_kernel column %0d beyond line buffer", col_cnt);

   a_no_dv_in_reset : assert property (
      @(posedge clk) !resetb |-> !px.dv
   ) else $error("uv_kernel item valid while in reset");

endmodule

//--- vlog.f
yuv_stream_pkg.sv
yuv_format_pkg.sv
yuv_pixel_if.sv
uv_kernel.sv
word_packer.sv
yuv420_stream_top.sv
tb_yuv420.sv

//--- word_packer.sv
module word_packer (
   input  logic                                 clk,
   input  logic                                 resetb,
   yuv_pixel_if.dst                             px,
   output logic                                 dvo,
   output yuv_stream_pkg::dtype_t               dtypeo,
   output logic [yuv_format_pkg::WORD_BITS-1:0] datao
);
   import yuv_stream_pkg::*;
   import yuv_format_pkg::*;

   localparam int YUV_BITS = 3 * PIXEL_BITS;

   logic pixel;
   logic frame_start;
   logic frame_end;
   logic header_start;
   logic header_word;
   logic header_end;

   // oldest byte sits highest, new bytes shift in at the bottom
   logic [OBUF_BITS-1:0] obuf;
   logic [OBUF_BITS-1:0] next_obuf;
   logic [OBUF_BITS-1:0] out_bits;
   logic [OPOS_BITS-1:0] opos;
   logic [OPOS_BITS-1:0] next_opos;
   logic [OPOS_BITS-1:0] rem_opos;
   logic [WORD_BITS-1:0] out_word;

   logic flush_req;
   logic flushed;

   assign pixel = px.dv && |(px.dtype & DTYPE_PIXEL_MASK);
   assign frame_start = px.dv && (px.dtype == DTYPE_FRAME_START);
   assign frame_end = px.dv && (px.dtype == DTYPE_FRAME_END);
   assign header_start = px.dv && (px.dtype == DTYPE_HEADER_START);
   assign header_word = px.dv && (px.dtype == DTYPE_HEADER);
   assign header_end = px.dv && (px.dtype == DTYPE_HEADER_END);

   // leftover bytes at frame end go out before the frame end token
   assign flush_req = frame_end && (opos != '0);

   always_comb begin
      if (flush_req) begin
         // left align the partial word so the pad lands in the top bytes
         next_obuf = obuf << (OPOS_BITS'(WORD_BITS) - opos);
         next_opos = OPOS_BITS'(WORD_BITS);
      end else if (px.emit_uv) begin
         next_obuf = {obuf[OBUF_BITS-YUV_BITS-1:0], px.y, px.u, px.v};
         next_opos = opos + OPOS_BITS'(YUV_BITS);
      end else begin
         next_obuf = {obuf[OBUF_BITS-PIXEL_BITS-1:0], px.y};
         next_opos = opos + OPOS_BITS'(PIXEL_BITS);
      end
   end

   // oldest 32 bits, then byte swapped so the first byte ends up low
   assign rem_opos = next_opos - OPOS_BITS'(WORD_BITS);
   assign out_bits = next_obuf >> rem_opos;
   assign out_word = {out_bits[7:0], out_bits[15:8], out_bits[23:16], out_bits[31:24]};

   always_ff @(posedge clk) begin
      if (pixel || flush_req) begin
         obuf <= next_obuf;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo <= 1'b0;
         dtypeo <= DTYPE_FRAME_START;
         datao <= '0;
         opos <= '0;
         flushed <= 1'b0;
      end else begin
         flushed <= flush_req;
         if (flush_req) begin
            dvo <= 1'b1;
            dtypeo <= DTYPE_PIXEL;
            datao <= out_word;
            opos <= '0;
         end else if (pixel) begin
            dtypeo <= px.dtype;
            if (next_opos >= OPOS_BITS'(WORD_BITS)) begin
               dvo <= 1'b1;
               datao <= out_word;
               opos <= rem_opos;
            end else begin
               dvo <= 1'b0;
               opos <= next_opos;
            end
         end else if (flushed) begin
            // the frame end token held back by the flush word
            dvo <= 1'b1;
            dtypeo <= DTYPE_FRAME_END;
            datao <= '0;
         end else if (header_word) begin
            // bit 0 of the fill position picks the half of the pair
            dtypeo <= DTYPE_HEADER;
            opos <= opos ^ OPOS_BITS'(1);
            if (opos[0]) begin
               datao[WORD_BITS-1:META_BITS] <= px.meta;
               dvo <= 1'b1;
            end else begin
               datao[META_BITS-1:0] <= px.meta;
               dvo <= 1'b0;
            end
         end else begin
            dvo <= px.dv;
            dtypeo <= px.dtype;
            datao <= '0;
            if (frame_start || header_start || header_end) begin
               opos <= '0;
            end
         end
      end
   end

   a_opos_in_range : assert property (
      @(posedge clk) disable iff (!resetb) int'(opos) <= OBUF_BITS
   ) else $error("word_packer fill position %0d beyond accumulator", opos);

   // both pipeline stages come out of reset empty
   a_quiet_after_reset : assert property (
      @(posedge clk) $rose(resetb) |=> !dvo
   ) else $error("word_packer output valid right after reset");

endmodule

//--- yuv420_stream_top.sv
module yuv420_stream_top #(
   parameter int MAX_COLS = yuv_format_pkg::MAX_COLS_DEFAULT
) (
   input  logic                                  clk,
   input  logic                                  resetb,
   input  logic                                  enable_420,

   // input item stream, one item per valid cycle
   input  logic                                  dvi,
   input  yuv_stream_pkg::dtype_t                dtypei,
   input  logic [yuv_stream_pkg::META_BITS-1:0]  meta_datai,
   input  logic [yuv_stream_pkg::PIXEL_BITS-1:0] yi,
   input  logic [yuv_stream_pkg::PIXEL_BITS-1:0] ui,
   input  logic [yuv_stream_pkg::PIXEL_BITS-1:0] vi,

   // packed output word stream
   output logic                                  dvo,
   output yuv_stream_pkg::dtype_t                dtypeo,
   output logic [yuv_format_pkg::WORD_BITS-1:0]  datao,

   // measured image size
   output logic [$clog2(MAX_COLS)-1:0]           num_rows,
   output logic [$clog2(MAX_COLS)-1:0]           num_cols
);

   yuv_pixel_if px ();

   // position tracking and chroma averaging
   uv_kernel #(
      .MAX_COLS(MAX_COLS)
   ) u_kernel (
      .clk        (clk),
      .resetb     (resetb),
      .enable_420 (enable_420),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .meta_datai (meta_datai),
      .yi         (yi),
      .ui         (ui),
      .vi         (vi),
      .num_rows   (num_rows),
      .num_cols   (num_cols),
      .px         (px.src)
   );

   // byte packing into output words
   word_packer u_packer (
      .clk    (clk),
      .resetb (resetb),
      .px     (px.dst),
      .dvo    (dvo),
      .dtypeo (dtypeo),
      .datao  (datao)
   );

endmodule

//--- yuv_format_pkg.sv
package yuv_format_pkg;

   // widest row the line buffer holds
   localparam int MAX_COLS_DEFAULT = 1288;

   // packed output word
   localparam int WORD_BITS = 32;

   // byte accumulator, one full word plus a three byte pixel
   localparam int OBUF_BITS = 56;

   // fill position counter, counts bits held in the accumulator
   localparam int OPOS_BITS = 6;

   // image size reported until the first frame end is seen
   localparam int RESET_ROWS = 720;
   localparam int RESET_COLS = 1280;

endpackage

//--- yuv_pixel_if.sv
interface yuv_pixel_if;
   import yuv_stream_pkg::*;

   // item valid and its type code
   logic dv;
   dtype_t dtype;

   // luma and the chroma pair, chroma already averaged in 420 mode
   logic [PIXEL_BITS-1:0] y;
   logic [PIXEL_BITS-1:0] u;
   logic [PIXEL_BITS-1:0] v;

   // high when the pixel carries Y,U,V and low when it carries Y only
   logic emit_uv;

   // header word
   logic [META_BITS-1:0] meta;

   modport src (
      output dv, dtype, y, u, v, emit_uv, meta
   );

   modport dst (
      input dv, dtype, y, u, v, emit_uv, meta
   );

endinterface

//--- yuv_stream_pkg.sv
package yuv_stream_pkg;

   // width of the item type field
   localparam int DTYPE_BITS = 4;

   // stream item type field
   typedef logic [DTYPE_BITS-1:0] dtype_t;

   // frame framing tokens
   localparam dtype_t DTYPE_FRAME_START = 4'd0;
   localparam dtype_t DTYPE_FRAME_END = 4'd1;

   // header framing and payload words
   localparam dtype_t DTYPE_HEADER_START = 4'd2;
   localparam dtype_t DTYPE_HEADER = 4'd3;
   localparam dtype_t DTYPE_HEADER_END = 4'd4;

   // row framing tokens
   localparam dtype_t DTYPE_ROW_START = 4'd5;
   localparam dtype_t DTYPE_ROW_END = 4'd6;

   // plain pixel code
   localparam dtype_t DTYPE_PIXEL = 4'd8;

   // any type with this bit set is a pixel
   localparam dtype_t DTYPE_PIXEL_MASK = 4'd8;

   // one Y, U or V sample
   localparam int PIXEL_BITS = 8;

   // one header word
   localparam int META_BITS = 16;

endpackage
